//--- files.f
+incdir+src
src/rv_decode_pkg.sv
src/decode_control.sv
src/imm_gen.sv
src/operand_select.sv
src/decode_stage.sv
test/tb_decode_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
RTL_TOP   ?= decode_stage
FILELIST  ?= files.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
FAIL_MSG  ?= FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF "PASS: all tests" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/tb_decode_stage.sv
`timescale 1ns/100ps
`include "rv_decode_config.svh"

module tb_decode_stage;
    import rv_decode_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int ARITH_N = 32;  // OP and OP-IMM, every funct3 and bit-30 pair
    localparam int LOAD_N  = 16;
    localparam int STORE_N = 16;
    localparam int FWD_N   = 48;
    localparam int BUB_N   = 24;
    localparam int GAP     = 3;   // bubbles that drain the pipe after each test
    localparam int CYCLE_LIMIT = RESET_CYCLES + ARITH_N + LOAD_N + STORE_N + FWD_N + BUB_N
                                 + 5 * GAP + 20;

    logic                   clk;
    logic                   reset;
    logic                   instr_valid;
    logic [`INSTR_W-1:0]    instr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       alu_result;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       ex_operand_a;
    logic [`XLEN-1:0]       ex_operand_b;
    alu_op_e                ex_alu_op;
    mem_op_e                ex_mem_op;
    wb_type_e               ex_wb_type;
    logic                   ex_reg_wb;
    logic                   ex_alu_wb;
    logic [`REG_ADDR_W-1:0] ex_rd;
    logic [`XLEN-1:0]       ex_store_data;
    logic                   ex_illegal;
    logic                   ex_valid;

    logic [31:0]      lfsr;
    logic [`XLEN-1:0] regfile [0:31];  // register file model, x0 reads zero
    int               errors = 0;
    int               checks = 0;
    int               tests = 0;
    int               cycles = 0;
    bit               checking = 0;

    // expected state of the ex register, also the previous instruction for forwarding
    alu_op_e                exp_alu_op;
    mem_op_e                exp_mem_op;
    wb_type_e               exp_wb_type;
    logic [`XLEN-1:0]       exp_operand_a;
    logic [`XLEN-1:0]       exp_operand_b;
    logic [`XLEN-1:0]       exp_store_data;
    logic [`REG_ADDR_W-1:0] exp_rd;
    logic                   exp_reg_wb;
    logic                   exp_alu_wb;
    logic                   exp_illegal;
    logic                   exp_valid;
    logic [`REG_ADDR_W-1:0] exp_rs1_addr;  // combinational, current instruction
    logic [`REG_ADDR_W-1:0] exp_rs2_addr;

    decode_stage decode_stage_inst (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .alu_result(alu_result),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .ex_operand_a(ex_operand_a), .ex_operand_b(ex_operand_b),
        .ex_alu_op(ex_alu_op), .ex_mem_op(ex_mem_op), .ex_wb_type(ex_wb_type),
        .ex_reg_wb(ex_reg_wb), .ex_alu_wb(ex_alu_wb), .ex_rd(ex_rd),
        .ex_store_data(ex_store_data), .ex_illegal(ex_illegal), .ex_valid(ex_valid)
    );

    assign rs1_data = regfile[rs1_addr];  // same-cycle read
    assign rs2_data = regfile[rs2_addr];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois LFSR, one step per bit
    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = b ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], next_bit()};
        return v;
    endfunction

    // random fields with the given opcode, funct3 and bit 30
    function automatic logic [31:0] make_instr(input logic [6:0] op, input logic [2:0] f3,
                                               input logic alt);
        logic [31:0] ins;
        ins = rand_bits(32);
        ins[6:0]   = op;
        ins[14:12] = f3;
        ins[30]    = alt;
        if (op == OP) begin
            ins[31]    = 1'b0;  // rest of funct7 is zero for OP
            ins[29:25] = 5'd0;
        end
        return ins;
    endfunction

    // expected decode of one instruction, previous instruction taken from exp_*
    function automatic void predict(input logic valid, input logic [31:0] ins,
                                    input logic [31:0] alu_res);
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        bub;
        logic        ill;
        logic        use1;
        logic        use2;
        logic        wb;
        logic        from_alu;
        logic        fwd;
        logic [31:0] imm;
        op   = ins[6:0];
        f3   = ins[14:12];
        rs1  = ins[19:15];
        rs2  = ins[24:20];
        bub  = !valid || (op == 7'd0);
        ill  = 1'b0;
        use1 = 1'b0;
        use2 = 1'b0;
        wb   = 1'b0;
        from_alu = 1'b0;
        imm  = '0;
        exp_alu_op  = NOP;
        exp_mem_op  = MEM_NOP;
        exp_wb_type = WORD;
        if (!bub) begin
            case (op)
                OP, OP_IMM: begin
                    use1 = 1'b1;
                    use2 = (op == OP);
                    wb   = 1'b1;
                    from_alu = 1'b1;
                    if (op == OP_IMM)
                        imm = {{20{ins[31]}}, ins[31:20]};
                    case (f3)
                        3'd0: exp_alu_op = (op == OP && ins[30]) ? SUB : ADD;  // no SUBI
                        3'd1: exp_alu_op = SLL;
                        3'd2: exp_alu_op = SLT;
                        3'd3: exp_alu_op = SLTU;
                        3'd4: exp_alu_op = XOR;
                        3'd5: exp_alu_op = ins[30] ? SRA : SRL;
                        3'd6: exp_alu_op = OR;
                        default: exp_alu_op = AND;
                    endcase
                end
                LOAD: begin
                    use1 = 1'b1;
                    wb   = 1'b1;   // from memory, alu write-back stays low
                    exp_alu_op = ADD;
                    exp_mem_op = MEM_LOAD;
                    imm = {{20{ins[31]}}, ins[31:20]};
                    case (f3)
                        3'd0: exp_wb_type = BYTE_SIGNED;
                        3'd1: exp_wb_type = HALF_SIGNED;
                        3'd2: exp_wb_type = WORD;
                        3'd4: exp_wb_type = BYTE_UNSIGNED;
                        3'd5: exp_wb_type = HALF_UNSIGNED;
                        default: ill = 1'b1;
                    endcase
                end
                STORE: begin
                    use1 = 1'b1;
                    use2 = 1'b1;
                    exp_alu_op = ADD;
                    exp_mem_op = MEM_STORE;
                    imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    case (f3)
                        3'd0: exp_wb_type = BYTE_SIGNED;
                        3'd1: exp_wb_type = HALF_SIGNED;
                        3'd2: exp_wb_type = WORD;
                        default: ill = 1'b1;
                    endcase
                end
                default: ill = 1'b1;
            endcase
        end
        if (ill) begin  // illegal slot carries nothing forward
            use1 = 1'b0;
            use2 = 1'b0;
            wb   = 1'b0;
            from_alu = 1'b0;
            imm  = '0;
            exp_alu_op  = NOP;
            exp_mem_op  = MEM_NOP;
            exp_wb_type = WORD;
        end
        fwd = use1 && (rs1 == exp_rd) && (exp_rd != 5'd0) && exp_reg_wb && exp_alu_wb;
        exp_rs1_addr   = use1 ? rs1 : 5'd0;
        exp_rs2_addr   = use2 ? rs2 : 5'd0;
        exp_operand_a  = fwd ? alu_res : (use1 ? regfile[rs1] : '0);
        exp_operand_b  = (use2 && exp_mem_op == MEM_NOP) ? regfile[rs2] : imm;  // OP only
        exp_store_data = (exp_mem_op == MEM_STORE) ? regfile[rs2] : '0;
        exp_rd      = wb ? ins[11:7] : 5'd0;
        exp_reg_wb  = wb;
        exp_alu_wb  = from_alu;
        exp_illegal = ill;
        exp_valid   = !bub && !ill;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_outputs();
        check("ex_operand_a", ex_operand_a, exp_operand_a);
        check("ex_operand_b", ex_operand_b, exp_operand_b);
        check("ex_alu_op", 32'(ex_alu_op), 32'(exp_alu_op));
        check("ex_mem_op", 32'(ex_mem_op), 32'(exp_mem_op));
        check("ex_wb_type", 32'(ex_wb_type), 32'(exp_wb_type));
        check("ex_reg_wb", 32'(ex_reg_wb), 32'(exp_reg_wb));
        check("ex_alu_wb", 32'(ex_alu_wb), 32'(exp_alu_wb));
        check("ex_rd", 32'(ex_rd), 32'(exp_rd));
        check("ex_store_data", ex_store_data, exp_store_data);
        check("ex_illegal", 32'(ex_illegal), 32'(exp_illegal));
        check("ex_valid", 32'(ex_valid), 32'(exp_valid));
    endtask

    // mid-cycle: ex_* hold the last instruction, inputs hold the next one
    initial begin
        forever begin
            @(negedge clk);
            if (checking) begin
                compare_outputs();
                predict(instr_valid, instr, alu_result);
                check("rs1_addr", 32'(rs1_addr), 32'(exp_rs1_addr));
                check("rs2_addr", 32'(rs2_addr), 32'(exp_rs2_addr));
            end
        end
    end

    task automatic drive(input logic valid, input logic [31:0] ins);
        @(posedge clk);
        #1;
        instr_valid = valid;
        instr       = ins;
        alu_result  = rand_bits(32);  // execute result of the held instruction
    endtask

    task automatic finish_test(input string name, input int start);
        repeat (GAP) drive(1'b0, rand_bits(32));
        @(negedge clk);
        #1;
        tests++;
        if (errors == start)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - start);
    endtask

    task automatic arith_sweep();
        int start;
        start = errors;
        for (int c = 0; c < 2; c++)
            for (int f = 0; f < 8; f++)
                for (int a = 0; a < 2; a++)
                    drive(1'b1, make_instr((c == 0) ? OP : OP_IMM, 3'(f), 1'(a)));
        finish_test("op_and_op_imm", start);
    endtask

    task automatic mem_sweep(input logic [6:0] op, input string name);
        int start;
        start = errors;
        for (int n = 0; n < 16; n++)
            drive(1'b1, make_instr(op, 3'(n % 8), 1'(rand_bits(1))));
        finish_test(name, start);
    endtask

    task automatic forward_chain();
        int          start;
        logic [1:0]  sel;
        logic [4:0]  last_rd;
        logic [31:0] ins;
        start   = errors;
        last_rd = 5'd0;
        for (int n = 0; n < FWD_N; n++) begin
            sel = 2'(rand_bits(2));
            case (sel)
                2'd0: ins = make_instr(OP, 3'(rand_bits(3)), 1'(rand_bits(1)));
                2'd1: ins = make_instr(OP_IMM, 3'(rand_bits(3)), 1'(rand_bits(1)));
                2'd2: ins = make_instr(LOAD, 3'd2, 1'(rand_bits(1)));   // LW
                default: ins = make_instr(STORE, 3'd2, 1'(rand_bits(1)));
            endcase
            if (rand_bits(2) != 32'd0)
                ins[19:15] = last_rd;  // mostly reuse the previous rd
            if (rand_bits(3) == 32'd0)
                ins[11:7] = 5'd0;      // sometimes write x0
            last_rd = ins[11:7];
            drive(1'b1, ins);
        end
        finish_test("forwarding", start);
    endtask

    task automatic bubble_mix();
        int          start;
        logic [1:0]  sel;
        logic [31:0] ins;
        start = errors;
        for (int n = 0; n < BUB_N; n++) begin
            sel = 2'(rand_bits(2));
            ins = make_instr(OP, 3'(rand_bits(3)), 1'(rand_bits(1)));
            case (sel)
                2'd0: drive(1'b0, ins);            // empty slot
                2'd1: begin
                    ins[6:0] = 7'd0;
                    drive(1'b1, ins);
                end
                2'd2: begin
                    ins[6:0] = 7'b011_0111;        // LUI, not decoded here
                    drive(1'b1, ins);
                end
                default: begin
                    ins[6:0] = 7'(rand_bits(7));   // any opcode
                    drive(1'b1, ins);
                end
            endcase
        end
        finish_test("bubble_and_illegal", start);
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [31:0] reset_instr;
        reset       = 1'b1;
        lfsr        = 32'hfe3e_4dc9;
        regfile[0]  = '0;
        for (int r = 1; r < 32; r++)
            regfile[r] = rand_bits(32);
        // a live LB with nonzero rd sits at the input, only reset keeps control inactive
        reset_instr = make_instr(LOAD, 3'd0, 1'b0);
        if (reset_instr[11:7] == 5'd0)
            reset_instr[11:7] = 5'd1;
        instr_valid = 1'b1;
        instr       = reset_instr;
        alu_result  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        exp_rd      = 5'd0;  // nothing held in execute, no bypass
        exp_reg_wb  = 1'b0;
        exp_alu_wb  = 1'b0;
        predict(1'b1, reset_instr, '0);  // datapath half follows the input
        exp_alu_op     = NOP;  // control half right after reset
        exp_mem_op     = MEM_NOP;
        exp_rd         = 5'd0;
        exp_reg_wb     = 1'b0;
        exp_alu_wb     = 1'b0;
        exp_illegal    = 1'b0;
        exp_valid      = 1'b0;
        checking       = 1'b1;
        @(negedge clk);
        #1;
        tests++;
        $display("test reset: %s", (errors == 0) ? "ok" : "errors");
        arith_sweep();
        mem_sweep(LOAD, "loads");
        mem_sweep(STORE, "stores");
        forward_chain();
        bubble_mix();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/100ps
`include "rv_decode_config.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instr_valid,
    input  logic [`INSTR_W-1:0]     instr,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    input  logic [`XLEN-1:0]        alu_result,
    output logic [`REG_ADDR_W-1:0]  rs1_addr,
    output logic [`REG_ADDR_W-1:0]  rs2_addr,
    output logic [`XLEN-1:0]        ex_operand_a,
    output logic [`XLEN-1:0]        ex_operand_b,
    output rv_decode_pkg::alu_op_e  ex_alu_op,
    output rv_decode_pkg::mem_op_e  ex_mem_op,
    output rv_decode_pkg::wb_type_e ex_wb_type,
    output logic                    ex_reg_wb,
    output logic                    ex_alu_wb,
    output logic [`REG_ADDR_W-1:0]  ex_rd,
    output logic [`XLEN-1:0]        ex_store_data,
    output logic                    ex_illegal,
    output logic                    ex_valid
);
    import rv_decode_pkg::*;

    alu_op_e           alu_op;
    mem_op_e           mem_op;
    wb_type_e          wb_type;
    imm_sel_e          imm_sel;
    logic              reg_wb;
    logic              alu_wb;
    logic              use_rs1;
    logic              use_rs2;
    logic              illegal;
    logic              bubble;
    logic [`XLEN-1:0]  imm;
    logic [`XLEN-1:0]  operand_a;
    logic [`XLEN-1:0]  operand_b;
    logic [`XLEN-1:0]  store_data;

    decode_control decode_control_inst (
        .clk(clk), .reset(reset),
        .instr_valid(instr_valid), .instr(instr),
        .alu_op(alu_op), .mem_op(mem_op), .wb_type(wb_type), .imm_sel(imm_sel),
        .reg_wb(reg_wb), .alu_wb(alu_wb), .use_rs1(use_rs1), .use_rs2(use_rs2),
        .illegal(illegal), .bubble(bubble)
    );

    imm_gen imm_gen_inst (.instr(instr), .imm_sel(imm_sel), .imm(imm));

    // held rd and flags of the instruction in execute drive the bypass
    operand_select operand_select_inst (
        .clk(clk), .reset(reset), .instr(instr),
        .use_rs1(use_rs1), .use_rs2(use_rs2), .imm_sel(imm_sel), .mem_op(mem_op),
        .imm(imm), .rs1_data(rs1_data), .rs2_data(rs2_data), .alu_result(alu_result),
        .rd_q(ex_rd), .reg_wb_q(ex_reg_wb), .alu_wb_q(ex_alu_wb),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .operand_a(operand_a), .operand_b(operand_b), .store_data(store_data)
    );

    // control half of the decode/execute register
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_alu_op  <= NOP;
            ex_mem_op  <= MEM_NOP;
            ex_reg_wb  <= 1'b0;
            ex_alu_wb  <= 1'b0;
            ex_rd      <= '0;
            ex_illegal <= 1'b0;
            ex_valid   <= 1'b0;
        end else begin
            ex_alu_op  <= alu_op;
            ex_mem_op  <= mem_op;
            ex_reg_wb  <= reg_wb;
            ex_alu_wb  <= alu_wb;
            ex_rd      <= reg_wb ? instr[`RD_HI:`RD_LO] : '0;  // stores carry no rd
            ex_illegal <= illegal;
            ex_valid   <= !bubble && !illegal;
        end
    end

    // datapath half, overwritten every cycle
    always_ff @(posedge clk) begin
        ex_operand_a  <= operand_a;
        ex_operand_b  <= operand_b;
        ex_store_data <= store_data;
        ex_wb_type    <= wb_type;
    end

    // an illegal slot must reach execute without side effects
    ex_illegal_inert: assert property (@(posedge clk) disable iff (reset)
        ex_illegal |-> !ex_reg_wb && (ex_mem_op == MEM_NOP));

    // the register comes out of reset empty
    ex_empty_after_reset: assert property (@(posedge clk)
        reset |=> !ex_valid && !ex_reg_wb);

endmodule

//--- src/operand_select.sv
`timescale 1ns/100ps
`include "rv_decode_config.svh"

module operand_select (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`INSTR_W-1:0]     instr,
    input  logic                    use_rs1,
    input  logic                    use_rs2,
    input  rv_decode_pkg::imm_sel_e imm_sel,
    input  rv_decode_pkg::mem_op_e  mem_op,
    input  logic [`XLEN-1:0]        imm,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    input  logic [`XLEN-1:0]        alu_result,   // execute result of the held instruction
    input  logic [`REG_ADDR_W-1:0]  rd_q,
    input  logic                    reg_wb_q,
    input  logic                    alu_wb_q,
    output logic [`REG_ADDR_W-1:0]  rs1_addr,
    output logic [`REG_ADDR_W-1:0]  rs2_addr,
    output logic [`XLEN-1:0]        operand_a,
    output logic [`XLEN-1:0]        operand_b,
    output logic [`XLEN-1:0]        store_data
);
    import rv_decode_pkg::*;

    logic fwd_a;  // rs1 written by the instruction now in execute

    // unused ports read x0 so the register file sees no spurious access
    assign rs1_addr = use_rs1 ? instr[`RS1_HI:`RS1_LO] : '0;
    assign rs2_addr = use_rs2 ? instr[`RS2_HI:`RS2_LO] : '0;

    // a load in execute has no result yet, only ALU writers forward
    assign fwd_a = use_rs1 && (rs1_addr == rd_q) && (rd_q != '0)
                   && reg_wb_q && alu_wb_q;

    assign operand_a = fwd_a   ? alu_result :
                       use_rs1 ? rs1_data   : '0;

    // immediate wins for OP-IMM, LOAD and STORE
    always_comb begin
        if (imm_sel != IMM_NONE)
            operand_b = imm;
        else if (use_rs2)
            operand_b = rs2_data;  // OP
        else
            operand_b = '0;
    end

    assign store_data = (mem_op == MEM_STORE) ? rs2_data : '0;

    // operand A of x0 always comes from the register file and never from the bypass
    fwd_not_x0: assert property (@(posedge clk) disable iff (reset)
        (use_rs1 && (rs1_addr == '0)) |-> (operand_a == rs1_data));

endmodule

//--- src/imm_gen.sv
`timescale 1ns/100ps
`include "rv_decode_config.svh"

module imm_gen (
    input  logic [`INSTR_W-1:0]     instr,
    input  rv_decode_pkg::imm_sel_e imm_sel,
    output logic [`XLEN-1:0]        imm
);
    import rv_decode_pkg::*;

    logic [`IMM_W-1:0]       imm_i;  // raw 12-bit fields
    logic [`IMM_W-1:0]       imm_s;
    logic [`XLEN-`IMM_W-1:0] sign_ext;

    // I type, one contiguous slice
    assign imm_i = instr[`IMM_I_HI:`IMM_I_LO];

    // S type split around rs2 and rs1, low five bits sit in the rd slot
    assign imm_s = {instr[`IMM_S_HI:`IMM_S_LO], instr[`RD_HI:`RD_LO]};

    // both formats keep the sign in instruction bit 31
    assign sign_ext = {(`XLEN-`IMM_W){instr[`SIGN_BIT]}};

    always_comb begin
        case (imm_sel)
            IMM_I:   imm = {sign_ext, imm_i};
            IMM_S:   imm = {sign_ext, imm_s};
            default: imm = '0;  // OP, bubbles and illegal
        endcase
    end

endmodule

//--- src/decode_control.sv
`timescale 1ns/100ps
`include "rv_decode_config.svh"

module decode_control (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instr_valid,
    input  logic [`INSTR_W-1:0]     instr,
    output rv_decode_pkg::alu_op_e  alu_op,
    output rv_decode_pkg::mem_op_e  mem_op,
    output rv_decode_pkg::wb_type_e wb_type,
    output rv_decode_pkg::imm_sel_e imm_sel,
    output logic                    reg_wb,
    output logic                    alu_wb,   // 1 = write back from ALU, 0 = from memory
    output logic                    use_rs1,
    output logic                    use_rs2,
    output logic                    illegal,
    output logic                    bubble
);
    import rv_decode_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;        // bit 30
    alu_op_e    alu_op_d;   // raw decode, before illegal gating
    mem_op_e    mem_op_d;
    wb_type_e   wb_type_d;
    imm_sel_e   imm_sel_d;
    logic       reg_wb_d;
    logic       alu_wb_d;
    logic       use_rs1_d;
    logic       use_rs2_d;

    // funct3 to ALU op, shared by OP and OP-IMM
    // SUB only exists in the register form, ADDI keeps bit 30 as immediate
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt_bit,
                                         input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && alt_bit) ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt_bit ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[`OPCODE_HI:`OPCODE_LO]);
    assign funct3 = instr[`FUNCT3_HI:`FUNCT3_LO];
    assign alt    = instr[`ALT_BIT];

    // empty slot or all-zero opcode is a pipeline bubble
    assign bubble = !instr_valid || (instr[`OPCODE_HI:`OPCODE_LO] == '0);

    always_comb begin
        alu_op_d  = NOP;       // inactive defaults
        mem_op_d  = MEM_NOP;
        wb_type_d = WORD;
        imm_sel_d = IMM_NONE;
        reg_wb_d  = 1'b0;
        alu_wb_d  = 1'b0;
        use_rs1_d = 1'b0;
        use_rs2_d = 1'b0;
        illegal   = 1'b0;
        if (!bubble) begin
            case (opcode)
                OP: begin
                    alu_op_d  = arith_op(funct3, alt, 1'b1);
                    reg_wb_d  = 1'b1;
                    alu_wb_d  = 1'b1;
                    use_rs1_d = 1'b1;
                    use_rs2_d = 1'b1;
                end
                OP_IMM: begin
                    alu_op_d  = arith_op(funct3, alt, 1'b0);
                    imm_sel_d = IMM_I;
                    reg_wb_d  = 1'b1;
                    alu_wb_d  = 1'b1;
                    use_rs1_d = 1'b1;
                end
                LOAD: begin
                    alu_op_d  = ADD;   // address = rs1 + imm
                    mem_op_d  = MEM_LOAD;
                    imm_sel_d = IMM_I;
                    reg_wb_d  = 1'b1;  // result comes from memory
                    use_rs1_d = 1'b1;
                    case (funct3)
                        3'b000:  wb_type_d = BYTE_SIGNED;    // LB
                        3'b001:  wb_type_d = HALF_SIGNED;    // LH
                        3'b010:  wb_type_d = WORD;           // LW
                        3'b100:  wb_type_d = BYTE_UNSIGNED;  // LBU
                        3'b101:  wb_type_d = HALF_UNSIGNED;  // LHU
                        default: illegal   = 1'b1;
                    endcase
                end
                STORE: begin
                    alu_op_d  = ADD;
                    mem_op_d  = MEM_STORE;
                    imm_sel_d = IMM_S;
                    use_rs1_d = 1'b1;  // base
                    use_rs2_d = 1'b1;  // store data
                    case (funct3)
                        3'b000:  wb_type_d = BYTE_SIGNED;  // SB
                        3'b001:  wb_type_d = HALF_SIGNED;  // SH
                        3'b010:  wb_type_d = WORD;         // SW
                        default: illegal   = 1'b1;
                    endcase
                end
                default: illegal = 1'b1;  // opcode outside the supported set
            endcase
        end
    end

    // an illegal instruction leaves the pipeline like a bubble
    assign alu_op  = illegal ? NOP      : alu_op_d;
    assign mem_op  = illegal ? MEM_NOP  : mem_op_d;
    assign wb_type = illegal ? WORD     : wb_type_d;
    assign imm_sel = illegal ? IMM_NONE : imm_sel_d;
    assign reg_wb  = reg_wb_d  && !illegal;
    assign alu_wb  = alu_wb_d  && !illegal;
    assign use_rs1 = use_rs1_d && !illegal;
    assign use_rs2 = use_rs2_d && !illegal;

    // a written register takes either the ALU or the load result, never both
    wb_one_source: assert property (@(posedge clk) disable iff (reset)
        reg_wb |-> (alu_wb != (mem_op == MEM_LOAD)));

endmodule

//--- src/rv_decode_pkg.sv
package rv_decode_pkg;

    // major opcodes handled by this stage
    typedef enum logic [6:0] {
        OP     = 7'b011_0011,  // register-register
        OP_IMM = 7'b001_0011,  // register-immediate
        LOAD   = 7'b000_0011,
        STORE  = 7'b010_0011
    } opcode_e;

    // operation code handed to the execute stage
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        SLL  = 4'd3,
        SLT  = 4'd4,
        SLTU = 4'd5,
        XOR  = 4'd6,
        SRL  = 4'd7,
        SRA  = 4'd8,
        OR   = 4'd9,
        AND  = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NOP   = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // access width and extension for loads, width only for stores
    typedef enum logic [2:0] {
        WORD          = 3'd0,
        BYTE_SIGNED   = 3'd1,
        HALF_SIGNED   = 3'd2,
        BYTE_UNSIGNED = 3'd3,
        HALF_UNSIGNED = 3'd4
    } wb_type_e;

    typedef enum logic [1:0] {
        IMM_NONE = 2'd0,
        IMM_I    = 2'd1,  // loads and OP-IMM
        IMM_S    = 2'd2   // stores
    } imm_sel_e;

endpackage

//--- src/rv_decode_config.svh
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// datapath and register file widths
`define XLEN        32
`define REG_ADDR_W  5
`define INSTR_W     32
`define IMM_W       12  // I and S immediates before extension

// base instruction fields
`define OPCODE_HI   6
`define OPCODE_LO   0
`define RD_HI       11  // also low half of the S immediate
`define RD_LO       7
`define FUNCT3_HI   14
`define FUNCT3_LO   12
`define RS1_HI      19
`define RS1_LO      15
`define RS2_HI      24
`define RS2_LO      20
`define ALT_BIT     30  // funct7 alternate bit, SUB and SRA
`define SIGN_BIT    31

// immediate slices
`define IMM_I_HI    31
`define IMM_I_LO    20
`define IMM_S_HI    31  // upper seven bits of the S immediate
`define IMM_S_LO    25

`endif
